// File: hw/in_frame_meter.sv
`timescale 1ns/1ps
`include "scaler_defs.svh"

module in_frame_meter
	import scaler_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_pix_ce,
	input  logic    i_hblank,
	input  logic    i_vblank,
	output logic    o_frame_start,
	output logic    o_locked,
	output hcount_t o_width,
	output vcount_t o_height
);

	// Expected geometry
	localparam hcount_t W_EXP = hcount_t'(`IN_H_ACTIVE);
	localparam vcount_t H_EXP = vcount_t'(`IN_V_ACTIVE);

	meter_state_t state;
	logic         hblank_q;
	logic         vblank_q;
	logic         active;
	logic         line_start;
	logic         line_end;
	logic         frame_end;
	logic         frame_match;
	hcount_t      px_cnt;
	hcount_t      first_w;
	vcount_t      ln_cnt;

	////////////////////////////////////////
	// Blanking edges
	////////////////////////////////////////

	assign active = i_pix_ce && !i_hblank && !i_vblank;
	assign line_start = active && hblank_q;
	assign line_end = i_pix_ce && i_hblank && !hblank_q;
	assign o_frame_start = i_pix_ce && !i_vblank && vblank_q;
	assign frame_end = i_pix_ce && i_vblank && !vblank_q;

	// Blank state of the previous enabled sample
	// Reset counts as blanking
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hblank_q <= 1'b1;
			vblank_q <= 1'b1;
		end else if (i_pix_ce) begin
			hblank_q <= i_hblank;
			vblank_q <= i_vblank;
		end
	end

	////////////////////////////////////////
	// Width and height counters
	////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			px_cnt <= '0;
			ln_cnt <= '0;
			first_w <= '0;
		end else begin
			// Active pixels on the current line
			if (line_start) begin
				px_cnt <= hcount_t'(1);
			end else if (active) begin
				px_cnt <= px_cnt + 1'b1;
			end
			// Active lines since frame start
			if (o_frame_start) begin
				ln_cnt <= vcount_t'(1);
			end else if (line_start) begin
				ln_cnt <= ln_cnt + 1'b1;
			end
			// Width taken from the first line only
			if (line_end && (ln_cnt == vcount_t'(1))) begin
				first_w <= px_cnt;
			end
		end
	end

	////////////////////////////////////////
	// Lock FSM
	////////////////////////////////////////

	assign frame_match = (first_w == W_EXP) && (ln_cnt == H_EXP);
	assign o_locked = (state == MTR_LOCKED);

	// Steps once per frame, at the start of vertical blanking
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= MTR_SEARCH;
			o_width <= '0;
			o_height <= '0;
		end else if (frame_end) begin
			o_width <= first_w;
			o_height <= ln_cnt;
			case (state)
				MTR_SEARCH: begin
					if (frame_match) begin
						state <= MTR_MEASURE;
					end
				end
				MTR_MEASURE: begin
					state <= frame_match ? MTR_LOCKED : MTR_SEARCH;
				end
				default: begin
					// Any bad frame drops lock
					if (!frame_match) begin
						state <= MTR_SEARCH;
					end
				end
			endcase
		end
	end

	// Start pulse lasts one clock of the pixel enable
	a_frame_start_single: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_frame_start |=> !o_frame_start
	);

endmodule

// File: hw/line_doubler.sv
`timescale 1ns/1ps
`include "scaler_defs.svh"

module line_doubler
	import scaler_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst_n,
	input  logic   i_pix_ce,
	input  pixel_t i_pixel,
	input  logic   i_hblank,
	input  logic   i_vblank,
	input  logic   i_frame_start,
	input  logic   i_locked,
	input  logic   i_out_hblank,
	input  logic   i_out_vblank,
	output pixel_t o_pixel
);

	// Line buffer address width
	localparam int AW = $clog2(`IN_H_ACTIVE);
	localparam hcount_t W_MAX = hcount_t'(`IN_H_ACTIVE);
	// Output raster in counter widths
	localparam hcount_t H_ACT = hcount_t'(`OUT_H_ACTIVE);
	localparam hcount_t H_LAST = hcount_t'(`OUT_H_TOTAL - 1);
	localparam vcount_t V_ACT = vcount_t'(`OUT_V_ACTIVE);
	localparam vcount_t V_LAST = vcount_t'(`OUT_V_TOTAL - 1);

	// Ping-pong buffers, selected by input line parity
	pixel_t line_buf [2][`IN_H_ACTIVE];

	logic          wr_en;
	logic          wr_par;
	logic          wr_buf;
	hcount_t       wr_addr;
	logic          out_hblank_q;
	logic          out_vblank_q;
	logic          out_hfall;
	logic          out_vfall;
	hcount_t       col_q;
	hcount_t       cur_col;
	hcount_t       nx_col;
	vcount_t       ln_q;
	vcount_t       cur_line;
	vcount_t       nx_line;
	vcount_t       src_line;
	logic          nx_active;
	logic          rd_buf;
	logic [AW-1:0] rd_addr;
	pixel_t        rd_pix;

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////

	assign wr_en = i_pix_ce && !i_hblank && !i_vblank;
	// First line of a frame always lands in buffer 0
	assign wr_buf = i_frame_start ? 1'b0 : wr_par;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_par <= 1'b0;
			wr_addr <= '0;
		end else if (i_frame_start) begin
			wr_par <= 1'b0;
			wr_addr <= hcount_t'(1);
		end else if (wr_en) begin
			wr_addr <= wr_addr + 1'b1;
		end else if (i_pix_ce && i_hblank) begin
			// Flip buffers only after a line that had pixels
			if (wr_addr != '0) begin
				wr_par <= ~wr_par;
			end
			wr_addr <= '0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (wr_en) begin
			line_buf[wr_buf][wr_addr[AW-1:0]] <= i_pixel;
		end
	end

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////

	// Position shown now, resynced on falling blank edges
	assign out_hfall = out_hblank_q && !i_out_hblank;
	assign out_vfall = out_vblank_q && !i_out_vblank;
	assign cur_col = out_hfall ? '0 : col_q;
	assign cur_line = out_vfall ? '0 : ln_q;

	// Position shown on the next clock
	assign nx_col = (cur_col == H_LAST) ? '0 : cur_col + 1'b1;
	assign nx_line = (cur_col != H_LAST) ? cur_line :
		(cur_line == V_LAST) ? '0 : cur_line + 1'b1;
	assign nx_active = (nx_col < H_ACT) && (nx_line < V_ACT);

	// Two output lines per input line, two clocks per input pixel
	assign src_line = nx_line / vcount_t'(`SCALE);
	assign rd_buf = src_line[0];
	assign rd_addr = AW'(nx_col / hcount_t'(`SCALE));
	assign rd_pix = line_buf[rd_buf][rd_addr];

	// Pixel register lines up with the registered blanks
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			out_hblank_q <= 1'b1;
			out_vblank_q <= 1'b1;
			col_q <= '0;
			ln_q <= '0;
			o_pixel <= '0;
		end else begin
			out_hblank_q <= i_out_hblank;
			out_vblank_q <= i_out_vblank;
			col_q <= nx_col;
			ln_q <= nx_line;
			o_pixel <= (i_locked && nx_active) ? rd_pix : '0;
		end
	end

	// Input lines never run past the buffer
	a_wr_addr_range: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		wr_en |-> (wr_addr < W_MAX)
	);

endmodule

// File: hw/out_raster_gen.sv
`timescale 1ns/1ps
`include "scaler_defs.svh"

module out_raster_gen
	import scaler_pkg::*;
(
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_frame_start,
	output logic o_hblank,
	output logic o_vblank,
	output logic o_hsync_n,
	output logic o_vsync_n
);

	// Horizontal windows
	localparam hcount_t H_ACT = hcount_t'(`OUT_H_ACTIVE);
	localparam hcount_t H_LAST = hcount_t'(`OUT_H_TOTAL - 1);
	localparam hcount_t HS_BEG = hcount_t'(`OUT_HS_START);
	localparam hcount_t HS_END = hcount_t'(`OUT_HS_START + `OUT_HS_LEN);
	// Vertical windows
	localparam vcount_t V_ACT = vcount_t'(`OUT_V_ACTIVE);
	localparam vcount_t V_LAST = vcount_t'(`OUT_V_TOTAL - 1);
	localparam vcount_t VS_BEG = vcount_t'(`OUT_VS_START);
	localparam vcount_t VS_END = vcount_t'(`OUT_VS_START + `OUT_VS_LEN);
	// Alignment delay
	localparam int DLY_W = $clog2(`ALIGN_DELAY);
	localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(`ALIGN_DELAY - 1);

	logic [DLY_W-1:0] dly_cnt;
	logic             dly_run;
	logic             align;
	logic             running;
	hcount_t          h_cnt;
	vcount_t          v_cnt;
	logic             hs_win;
	logic             vs_win;

	////////////////////////////////////////
	// Frame alignment
	////////////////////////////////////////

	// Counters hit 0,0 one input line after frame start
	assign align = dly_run && (dly_cnt == DLY_LAST);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			dly_run <= 1'b0;
			dly_cnt <= '0;
		end else if (i_frame_start) begin
			dly_run <= 1'b1;
			dly_cnt <= DLY_W'(1);
		end else if (align) begin
			dly_run <= 1'b0;
		end else if (dly_run) begin
			dly_cnt <= dly_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Raster counters
	////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			running <= 1'b0;
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (align) begin
			running <= 1'b1;
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Sync windows sit inside blanking
	assign hs_win = (h_cnt >= HS_BEG) && (h_cnt < HS_END);
	assign vs_win = (v_cnt >= VS_BEG) && (v_cnt < VS_END);

	// All blank, no sync until first alignment
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_hblank <= 1'b1;
			o_vblank <= 1'b1;
			o_hsync_n <= 1'b1;
			o_vsync_n <= 1'b1;
		end else begin
			o_hblank <= !running || (h_cnt >= H_ACT);
			o_vblank <= !running || (v_cnt >= V_ACT);
			o_hsync_n <= !(running && hs_win);
			o_vsync_n <= !(running && vs_win);
		end
	end

	// Vertical sync never leaks into the picture
	a_vsync_in_vblank: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!o_vsync_n |-> o_vblank
	);

endmodule

// File: hw/scaler_defs.svh
`ifndef SCALER_DEFS_SVH
`define SCALER_DEFS_SVH

////////////////////////////////////////
// Input raster
////////////////////////////////////////

// Bits per colour component
`define COMP_W 4

// Input pixels per line
`define IN_H_ACTIVE 16
`define IN_H_TOTAL 20

// Input lines per frame
`define IN_V_ACTIVE 12
`define IN_V_TOTAL 15

// Clocks per input pixel
`define PIX_DIV 4

////////////////////////////////////////
// Output raster
////////////////////////////////////////

// Integer scale factor, both axes
`define SCALE 2

// Derived output geometry
`define OUT_H_ACTIVE (`IN_H_ACTIVE * `SCALE)
`define OUT_H_TOTAL (`IN_H_TOTAL * `SCALE)
`define OUT_V_ACTIVE (`IN_V_ACTIVE * `SCALE)
`define OUT_V_TOTAL (`IN_V_TOTAL * `SCALE)

// Sync windows inside blanking
`define OUT_HS_START 34
`define OUT_HS_LEN 4
`define OUT_VS_START 26
`define OUT_VS_LEN 2

// One input line in clocks
`define ALIGN_DELAY (`IN_H_TOTAL * `PIX_DIV)

`endif

// File: hw/scaler_pkg.sv
`include "scaler_defs.svh"

package scaler_pkg;

	////////////////////////////////////////
	// Video data
	////////////////////////////////////////

	// RGB word, red on top then green then blue
	typedef logic [3*`COMP_W-1:0] pixel_t;

	////////////////////////////////////////
	// Raster coordinates
	////////////////////////////////////////

	// Covers the 40-clock output line
	typedef logic [6:0] hcount_t;

	// Covers the 30-line output frame
	typedef logic [5:0] vcount_t;

	// Lock FSM of the frame meter
	typedef enum logic [1:0] {
		MTR_SEARCH,
		MTR_MEASURE,
		MTR_LOCKED
	} meter_state_t;

endpackage

// File: hw/video_scaler_top.sv
`timescale 1ns/1ps

module video_scaler_top
	import scaler_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_pix_ce,
	input  pixel_t  i_pixel,
	input  logic    i_hblank,
	input  logic    i_vblank,
	output pixel_t  o_pixel,
	output logic    o_hblank,
	output logic    o_vblank,
	output logic    o_hsync_n,
	output logic    o_vsync_n,
	output logic    o_locked,
	output hcount_t o_width,
	output vcount_t o_height
);

	// First input pixel of each frame
	logic frame_start;

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////

	in_frame_meter meter_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_pix_ce     (i_pix_ce),
		.i_hblank     (i_hblank),
		.i_vblank     (i_vblank),
		.o_frame_start(frame_start),
		.o_locked     (o_locked),
		.o_width      (o_width),
		.o_height     (o_height)
	);

	// Buffers written at input rate, read at output rate
	line_doubler doubler_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_pix_ce     (i_pix_ce),
		.i_pixel      (i_pixel),
		.i_hblank     (i_hblank),
		.i_vblank     (i_vblank),
		.i_frame_start(frame_start),
		.i_locked     (o_locked),
		.i_out_hblank (o_hblank),
		.i_out_vblank (o_vblank),
		.o_pixel      (o_pixel)
	);

	////////////////////////////////////////
	// Output timing
	////////////////////////////////////////

	out_raster_gen raster_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_frame_start(frame_start),
		.o_hblank     (o_hblank),
		.o_vblank     (o_vblank),
		.o_hsync_n    (o_hsync_n),
		.o_vsync_n    (o_vsync_n)
	);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the video scaler testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f tb.f --top-module tb_video_scaler -Mdir "$OBJ"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_video_scaler" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ "$run_status" -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
echo "Simulation passed"
exit 0

// File: tb.f
+incdir+hw
hw/scaler_pkg.sv
hw/in_frame_meter.sv
hw/line_doubler.sv
hw/out_raster_gen.sv
hw/video_scaler_top.sv
verification/tb_video_scaler.sv

// File: verification/tb_video_scaler.sv
`timescale 1ns/1ps
`include "scaler_defs.svh"

module tb_video_scaler
	import scaler_pkg::*;
();

	// Run length and the odd frame
	localparam int NUM_FRAMES = 10;
	localparam int BAD_FRAME = 5;
	localparam int BAD_WIDTH = 12;
	localparam int FRAME_CLKS = `IN_H_TOTAL * `IN_V_TOTAL * `PIX_DIV;
	localparam int WATCHDOG_CLKS = (NUM_FRAMES + 2) * FRAME_CLKS + 200;
	// Vertical sync length in clocks
	localparam int VS_CLKS = `OUT_VS_LEN * `OUT_H_TOTAL;

	logic    i_clk;
	logic    i_rst_n;
	logic    i_pix_ce;
	pixel_t  i_pixel;
	logic    i_hblank;
	logic    i_vblank;
	pixel_t  o_pixel;
	logic    o_hblank;
	logic    o_vblank;
	logic    o_hsync_n;
	logic    o_vsync_n;
	logic    o_locked;
	hcount_t o_width;
	vcount_t o_height;

	// Content and width of every frame sent
	pixel_t frame_mem [NUM_FRAMES][`IN_V_ACTIVE][`IN_H_ACTIVE];
	int     frame_w [NUM_FRAMES];
	integer seed;
	int     in_frame;
	int     good_run;
	int     exp_pix_frames;

	// Output side bookkeeping
	int   out_frame;
	int   ox;
	int   oy;
	int   hs_pulses;
	int   vs_pulses;
	int   hs_len;
	int   vs_len;
	int   pix_frames;
	bit   chk_on;
	logic hb_q;
	logic vb_q;
	logic hs_q;
	logic vs_q;
	logic lk_q;

	video_scaler_top dut_i (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_pix_ce (i_pix_ce),
		.i_pixel  (i_pixel),
		.i_hblank (i_hblank),
		.i_vblank (i_vblank),
		.o_pixel  (o_pixel),
		.o_hblank (o_hblank),
		.o_vblank (o_vblank),
		.o_hsync_n(o_hsync_n),
		.o_vsync_n(o_vsync_n),
		.o_locked (o_locked),
		.o_width  (o_width),
		.o_height (o_height)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t: %s got %0h expected %0h", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "value mismatch");
		end
	endtask

	// Frame, column and row all move the value
	function automatic pixel_t make_pixel(input int f, input int x, input int y,
		input int rnd);
		int mix;
		mix = (f * 331) + (x * 17) + (y * 113);
		return pixel_t'(mix ^ rnd);
	endfunction

	// Each input pixel covers a SCALE by SCALE output block
	function automatic pixel_t expected_pixel(input int f, input int x, input int y);
		return frame_mem[f][y / `SCALE][x / `SCALE];
	endfunction

	task automatic fill_frame(input int f, input int w);
		int x;
		int y;
		frame_w[f] = w;
		for (y = 0; y < `IN_V_ACTIVE; y++) begin
			for (x = 0; x < `IN_H_ACTIVE; x++) begin
				frame_mem[f][y][x] = make_pixel(f, x, y, $random(seed));
			end
		end
	endtask

	// One sample every PIX_DIV clocks
	task automatic send_sample(input pixel_t p, input logic hb, input logic vb);
		repeat (`PIX_DIV - 1) begin
			@(posedge i_clk);
			i_pix_ce <= 1'b0;
		end
		@(posedge i_clk);
		i_pix_ce <= 1'b1;
		i_pixel <= p;
		i_hblank <= hb;
		i_vblank <= vb;
	endtask

	task automatic send_frame(input int f);
		int     x;
		int     y;
		logic   hb;
		logic   vb;
		pixel_t p;
		in_frame = f;
		for (y = 0; y < `IN_V_TOTAL; y++) begin
			for (x = 0; x < `IN_H_TOTAL; x++) begin
				hb = (x >= frame_w[f]);
				vb = (y >= `IN_V_ACTIVE);
				// Junk in blanking, must never show
				if (hb || vb) begin
					p = pixel_t'(12'ha5a);
				end else begin
					p = frame_mem[f][y][x];
				end
				send_sample(p, hb, vb);
			end
		end
	endtask

	////////////////////////////////////////
	// Stimulus and lock checks
	////////////////////////////////////////

	initial begin
		int f;
		i_rst_n = 1'b0;
		i_pix_ce = 1'b0;
		i_pixel = '0;
		i_hblank = 1'b1;
		i_vblank = 1'b1;
		seed = 32'h1306c623;
		in_frame = 0;
		good_run = 0;
		exp_pix_frames = 0;
		repeat (8) @(posedge i_clk);
		i_rst_n <= 1'b1;
		// Idle outputs before any frame
		repeat (2) @(negedge i_clk);
		check_value("o_locked", 32'(o_locked), 32'd0);
		check_value("o_hblank", 32'(o_hblank), 32'd1);
		check_value("o_vblank", 32'(o_vblank), 32'd1);
		check_value("o_hsync_n", 32'(o_hsync_n), 32'd1);
		check_value("o_vsync_n", 32'(o_vsync_n), 32'd1);
		check_value("o_pixel", 32'(o_pixel), 32'd0);
		for (f = 0; f < NUM_FRAMES; f++) begin
			fill_frame(f, (f == BAD_FRAME) ? BAD_WIDTH : `IN_H_ACTIVE);
			// Locked from its first line and well formed
			if (good_run >= 2 && frame_w[f] == `IN_H_ACTIVE) begin
				exp_pix_frames++;
			end
			send_frame(f);
			// Lock needs two good frames in a row
			good_run = (frame_w[f] == `IN_H_ACTIVE) ? good_run + 1 : 0;
			@(negedge i_clk);
			check_value("o_locked", 32'(o_locked), (good_run >= 2) ? 32'd1 : 32'd0);
			check_value("o_width", 32'(o_width), frame_w[f]);
			check_value("o_height", 32'(o_height), `IN_V_ACTIVE);
		end
		// Blank input until the last checked output frame is done
		while (pix_frames < exp_pix_frames) begin
			send_sample(pixel_t'(0), 1'b1, 1'b1);
		end
		$display("PASS: all tests");
		$finish;
	end

	////////////////////////////////////////
	// Output compare
	////////////////////////////////////////

	initial begin
		chk_on = 1'b0;
		out_frame = 0;
		ox = 0;
		oy = 0;
		hs_pulses = 0;
		vs_pulses = 0;
		hs_len = 0;
		vs_len = 0;
		pix_frames = 0;
		hb_q = 1'b1;
		vb_q = 1'b1;
		hs_q = 1'b1;
		vs_q = 1'b1;
		lk_q = 1'b0;
		forever begin
			@(negedge i_clk);
			// Syncs only inside blanking
			if (chk_on && !o_hsync_n) begin
				check_value("o_hblank", 32'(o_hblank), 32'd1);
			end
			if (chk_on && !o_vsync_n) begin
				check_value("o_vblank", 32'(o_vblank), 32'd1);
			end
			// Black in blanking, and one clock after lock was low
			if (!lk_q || o_hblank || o_vblank) begin
				check_value("o_pixel", 32'(o_pixel), 32'd0);
			end
			// Sync pulse counts and widths
			if (!o_hsync_n) begin
				hs_len++;
				if (hs_q) begin
					hs_pulses++;
				end
			end else if (!hs_q) begin
				if (chk_on) begin
					check_value("o_hsync_n low clocks", hs_len, `OUT_HS_LEN);
				end
				hs_len = 0;
			end
			if (!o_vsync_n) begin
				vs_len++;
				if (vs_q) begin
					vs_pulses++;
				end
			end else if (!vs_q) begin
				if (chk_on) begin
					check_value("o_vsync_n low clocks", vs_len, VS_CLKS);
				end
				vs_len = 0;
			end
			// New output line
			if (hb_q && !o_hblank) begin
				if (chk_on) begin
					check_value("o_hsync_n pulses per line", hs_pulses, 1);
				end
				hs_pulses = 0;
				ox = 0;
			end
			// New output frame, picks up the input frame being written
			if (vb_q && !o_vblank) begin
				if (chk_on) begin
					check_value("o_vsync_n pulses per frame", vs_pulses, 1);
				end
				vs_pulses = 0;
				chk_on = o_locked;
				out_frame = in_frame;
				oy = 0;
			end
			if (!o_hblank && !o_vblank) begin
				if (chk_on && frame_w[out_frame] == `IN_H_ACTIVE) begin
					check_value("o_pixel", 32'(o_pixel),
						32'(expected_pixel(out_frame, ox, oy)));
				end
				ox++;
			end
			// End of an active line
			if (!hb_q && o_hblank && !o_vblank) begin
				if (chk_on) begin
					check_value("active pixels per line", ox, `OUT_H_ACTIVE);
				end
				oy++;
			end
			// End of the active area
			if (!vb_q && o_vblank) begin
				if (chk_on) begin
					check_value("active lines per frame", oy, `OUT_V_ACTIVE);
					if (frame_w[out_frame] == `IN_H_ACTIVE) begin
						pix_frames++;
					end
				end
			end
			hb_q = o_hblank;
			vb_q = o_vblank;
			hs_q = o_hsync_n;
			vs_q = o_vsync_n;
			lk_q = o_locked;
		end
	end

	////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////

	initial begin
		repeat (WATCHDOG_CLKS) @(posedge i_clk);
		$display("Timeout: the run did not finish within %0d clocks", WATCHDOG_CLKS);
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule
